//--- lb_bus_pkg.sv
// Local bus command struct, region codes, identification words and fixed read values
package lb_bus_pkg;

	// ----------------------------------------------------------------------
	// Address map
	// ----------------------------------------------------------------------

	// Upper address byte of the direct-write and mirror region
	localparam logic [7:0] local_upper = 8'h05;

	// Region a bus cycle falls into, decided from the upper byte
	typedef enum logic [1:0] {
		region_none  = 2'd0,
		region_bank  = 2'd1,
		region_local = 2'd2
	} lb_region_t;

	// One classified bus strobe
	typedef struct packed {
		logic        rd;
		logic        wr;
		lb_region_t  region;
		logic [4:0]  offset;
		logic [23:0] addr;
		logic [31:0] wdata;
	} lb_cmd_t;

	// ----------------------------------------------------------------------
	// Fixed read values
	// ----------------------------------------------------------------------

	// Identification words, ASCII, read at bank offsets 0 to 3
	localparam logic [31:0] id_word_0 = "LBsl";
	localparam logic [31:0] id_word_1 = "ave ";
	localparam logic [31:0] id_word_2 = "brd ";
	localparam logic [31:0] id_word_3 = "v1.0";

	// Unused bank offsets
	localparam logic [31:0] bank_default = "zzzz";

	// Anything outside the bank and local regions
	localparam logic [31:0] unmapped_value = 32'hdeadbeef;

endpackage

//--- board_pkg.sv
// Board control register struct, status struct, write offsets and field widths
package board_pkg;

	// Field widths
	localparam int duty_w   = 8;
	localparam int cfg_w    = 8;
	localparam int fault_w  = 16;
	localparam int uptime_w = 32;
	localparam int pin_w    = 9;

	// ----------------------------------------------------------------------
	// Direct-write offsets inside the local region
	// ----------------------------------------------------------------------
	localparam logic [4:0] off_led_user  = 5'd1;
	localparam logic [4:0] off_led1      = 5'd2;
	localparam logic [4:0] off_led2      = 5'd3;
	localparam logic [4:0] off_misc      = 5'd8;

	// Trigger pulses occupy off_trig_base up to off_trig_base + n_trig - 1
	localparam logic [4:0] off_trig_base = 5'd9;
	localparam int         n_trig        = 4;

	// Host writable control state
	typedef struct packed {
		logic              led_user;
		logic [duty_w-1:0] led1_duty;
		logic [duty_w-1:0] led2_duty;
		logic [cfg_w-1:0]  misc_config;
	} ctrl_regs_t;

	// Counters returned in the register bank
	typedef struct packed {
		logic [fault_w-1:0]  fault_count;
		logic [uptime_w-1:0] uptime;
	} status_t;

endpackage

//--- lb_decode.sv
// Bus strobe decoder producing a region-tagged read or write command
module lb_decode (
	input  logic                clk,
	input  logic [23:0]         addr,
	input  logic                control_strobe,
	input  logic                control_rd,
	input  logic [31:0]         data_out,
	output lb_bus_pkg::lb_cmd_t cmd
);

	logic in_bank;
	logic in_local;

	// Bank needs upper byte zero and the low nibble group zero
	assign in_bank  = (addr[23:16] == 8'h00) && (addr[7:4] == 4'h0);
	assign in_local = (addr[23:16] == lb_bus_pkg::local_upper);

	always_comb begin
		cmd.rd     = control_strobe & control_rd;
		cmd.wr     = control_strobe & ~control_rd;
		cmd.offset = addr[4:0];
		cmd.addr   = addr;
		cmd.wdata  = data_out;
		if (in_bank) begin
			cmd.region = lb_bus_pkg::region_bank;
		end else if (in_local) begin
			cmd.region = lb_bus_pkg::region_local;
		end else begin
			cmd.region = lb_bus_pkg::region_none;
		end
	end

	// ----------------------------------------------------------------------
	// Checks
	// ----------------------------------------------------------------------

	// Downstream blocks treat rd and wr as exclusive
	a_rd_wr_excl : assert property (
		@(posedge clk) !(cmd.rd && cmd.wr)
	) else $error("read and write asserted together");

endmodule

//--- lb_ctrl_regs.sv
// Direct-write control registers, configuration byte and one-cycle trigger pulses
module lb_ctrl_regs #(
	parameter logic [board_pkg::cfg_w-1:0] misc_config_default = '0
) (
	input  logic                           clk,
	input  logic                           rst,
	input  lb_bus_pkg::lb_cmd_t            cmd,
	output board_pkg::ctrl_regs_t          ctrl,
	output logic [board_pkg::n_trig-1:0]   trig
);

	logic local_wr;

	assign local_wr = cmd.wr && (cmd.region == lb_bus_pkg::region_local);

	// ----------------------------------------------------------------------
	// Control registers
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl.led_user    <= 1'b0;
			ctrl.led1_duty   <= '0;
			ctrl.led2_duty   <= '0;
			ctrl.misc_config <= misc_config_default;
		end else if (local_wr) begin
			case (cmd.offset)
				board_pkg::off_led_user: ctrl.led_user <= cmd.wdata[0];
				board_pkg::off_led1: ctrl.led1_duty <= cmd.wdata[board_pkg::duty_w-1:0];
				board_pkg::off_led2: ctrl.led2_duty <= cmd.wdata[board_pkg::duty_w-1:0];
				board_pkg::off_misc: ctrl.misc_config <= cmd.wdata[board_pkg::cfg_w-1:0];
				default: ;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// Trigger pulses
	// ----------------------------------------------------------------------

	// High for one cycle after the write edge, cleared otherwise
	always_ff @(posedge clk) begin
		if (rst) begin
			trig <= '0;
		end else begin
			for (int i = 0; i < board_pkg::n_trig; i++) begin
				trig[i] <= local_wr && (cmd.offset == board_pkg::off_trig_base + 5'(i));
			end
		end
	end

	// ----------------------------------------------------------------------
	// Checks
	// ----------------------------------------------------------------------

	a_trig_onehot : assert property (
		@(posedge clk) disable iff (rst) $onehot0(trig)
	) else $error("more than one trigger active");

endmodule

//--- lb_mirror.sv
// Mirror memory of local-region writes with synchronous readback
module lb_mirror #(
	parameter int mirror_aw = 5
) (
	input  logic                clk,
	input  lb_bus_pkg::lb_cmd_t cmd,
	output logic [31:0]         mirror_rdata
);

	localparam int depth = 1 << mirror_aw;

	logic [31:0]          mem [depth];
	logic [mirror_aw-1:0] waddr;
	logic                 local_wr;

	assign waddr    = cmd.addr[mirror_aw-1:0];
	assign local_wr = cmd.wr && (cmd.region == lb_bus_pkg::region_local);

	always_ff @(posedge clk) begin
		if (local_wr) begin
			mem[waddr] <= cmd.wdata;
		end
	end

	// Read in the same edge as stage one of the read pipeline
	always_ff @(posedge clk) begin
		if (cmd.rd) begin
			mirror_rdata <= mem[waddr];
		end
	end

endmodule

//--- led_pwm_status.sv
// PWM counter, LED duty compare, uptime and cross-domain fault counters
module led_pwm_status #(
	parameter int led_cw = 10
) (
	input  logic                  clk,
	input  logic                  rst,
	input  board_pkg::ctrl_regs_t ctrl,
	input  logic                  xdomain_fault,
	output board_pkg::status_t    status,
	output logic                  led1,
	output logic                  led2
);

	// Duty compare needs duty * 4 to fit in the counter
	if (led_cw < board_pkg::duty_w + 2) begin : g_cw_check
		$error("led_cw must be at least 10");
	end

	logic [led_cw-1:0] led_cc;
	logic              led_wrap;

	assign led_wrap = &led_cc;

	// ----------------------------------------------------------------------
	// PWM
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			led_cc <= '0;
			led1   <= 1'b0;
			led2   <= 1'b0;
		end else begin
			led_cc <= led_cc + 1'b1;
			led1   <= led_cc < led_cw'({ctrl.led1_duty, 2'b00});
			led2   <= led_cc < led_cw'({ctrl.led2_duty, 2'b00});
		end
	end

	// ----------------------------------------------------------------------
	// Counters
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			status <= '0;
		end else begin
			if (led_wrap)
				status.uptime <= status.uptime + 1'b1;
			// Wraps at 16 bits
			if (xdomain_fault)
				status.fault_count <= status.fault_count + 1'b1;
		end
	end

endmodule

//--- lb_read_mux.sv
// Two-stage read pipeline, bank word select then region select
module lb_read_mux (
	input  logic                          clk,
	input  logic                          rst,
	input  lb_bus_pkg::lb_cmd_t           cmd,
	input  board_pkg::ctrl_regs_t         ctrl,
	input  board_pkg::status_t            status,
	input  logic [board_pkg::pin_w-1:0]   pin_status,
	input  logic [31:0]                   mirror_rdata,
	output logic [31:0]                   data_in
);

	logic                   rd_r;
	lb_bus_pkg::lb_region_t region_r;
	logic [31:0]            bank_word;

	// ----------------------------------------------------------------------
	// Stage one
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst)
			rd_r <= 1'b0;
		else
			rd_r <= cmd.rd;
	end

	always_ff @(posedge clk) begin
		if (cmd.rd) begin
			region_r <= cmd.region;
			case (cmd.addr[3:0])
				4'h0: bank_word <= lb_bus_pkg::id_word_0;
				4'h1: bank_word <= lb_bus_pkg::id_word_1;
				4'h2: bank_word <= lb_bus_pkg::id_word_2;
				4'h3: bank_word <= lb_bus_pkg::id_word_3;
				4'h4: bank_word <= 32'(status.fault_count);
				4'h5: bank_word <= 32'(status.uptime);
				4'h6: bank_word <= 32'(ctrl.misc_config);
				4'h7: bank_word <= 32'({ctrl.led2_duty, ctrl.led1_duty});
				4'h8: bank_word <= 32'(pin_status);
				default: bank_word <= lb_bus_pkg::bank_default;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// Stage two
	// ----------------------------------------------------------------------

	// Result holds until the next read reaches stage two
	always_ff @(posedge clk) begin
		if (rst) begin
			data_in <= '0;
		end else if (rd_r) begin
			case (region_r)
				lb_bus_pkg::region_bank:  data_in <= bank_word;
				lb_bus_pkg::region_local: data_in <= mirror_rdata;
				default:                  data_in <= lb_bus_pkg::unmapped_value;
			endcase
		end
	end

endmodule

//--- lb_slave_top.sv
// Local bus slave top level with decoder, execute blocks and read pipeline
module lb_slave_top #(
	parameter int                          led_cw              = 10,
	parameter logic [board_pkg::cfg_w-1:0] misc_config_default = '0,
	parameter int                          mirror_aw           = 5
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [23:0]                   addr,
	input  logic                          control_strobe,
	input  logic                          control_rd,
	input  logic [31:0]                   data_out,
	output logic [31:0]                   data_in,
	input  logic                          xdomain_fault,
	input  logic [board_pkg::pin_w-1:0]   pin_status,
	output logic                          led_user_mode,
	output logic                          led1,
	output logic                          led2,
	output logic [3:0]                    cfg_enables,
	output logic [3:0]                    ext_config,
	output logic [board_pkg::n_trig-1:0]  trig
);

	lb_bus_pkg::lb_cmd_t   cmd;
	board_pkg::ctrl_regs_t ctrl;
	board_pkg::status_t    status;
	logic [31:0]           mirror_rdata;

	// ----------------------------------------------------------------------
	// Decode, execute, result
	// ----------------------------------------------------------------------
	lb_decode i_lb_decode (
		.clk, .addr, .control_strobe, .control_rd, .data_out, .cmd
	);

	lb_ctrl_regs #(.misc_config_default(misc_config_default)) i_lb_ctrl_regs (
		.clk, .rst, .cmd, .ctrl, .trig
	);

	lb_mirror #(.mirror_aw(mirror_aw)) i_lb_mirror (
		.clk, .cmd, .mirror_rdata
	);

	led_pwm_status #(.led_cw(led_cw)) i_led_pwm_status (
		.clk, .rst, .ctrl, .xdomain_fault, .status, .led1, .led2
	);

	lb_read_mux i_lb_read_mux (
		.clk, .rst, .cmd, .ctrl, .status, .pin_status, .mirror_rdata, .data_in
	);

	// Board enables from the configuration byte
	assign led_user_mode = ctrl.led_user;
	assign cfg_enables   = ctrl.misc_config[3:0];
	assign ext_config    = ctrl.misc_config[7:4];

endmodule

//--- lb_slave_tb.sv
// Directed testbench for the local bus slave with bus tasks, compare tasks and tests
module lb_slave_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int         led_cw              = 10;
	localparam logic [7:0] misc_config_default = 8'h5a;
	localparam int         mirror_aw           = 5;
	localparam int         pwm_period          = 1 << led_cw;
	localparam int         wait_limit          = 4 * pwm_period;

	logic        clk;
	logic        rst;
	logic [23:0] addr;
	logic        control_strobe;
	logic        control_rd;
	logic [31:0] data_out;
	logic [31:0] data_in;
	logic        xdomain_fault;
	logic [8:0]  pin_status;
	logic        led_user_mode;
	logic        led1;
	logic        led2;
	logic [3:0]  cfg_enables;
	logic [3:0]  ext_config;
	logic [3:0]  trig;

	integer                seed   = 32'hf2043d3f;
	logic [31:0]           mirror_exp [32];
	board_pkg::ctrl_regs_t ctrl_exp;

	lb_slave_top #(
		.led_cw(led_cw), .misc_config_default(misc_config_default), .mirror_aw(mirror_aw)
	) i_lb_slave_top (
		.clk, .rst, .addr, .control_strobe, .control_rd, .data_out, .data_in,
		.xdomain_fault, .pin_status, .led_user_mode, .led1, .led2,
		.cfg_enables, .ext_config, .trig
	);

	always #10 clk = ~clk;

	// ----------------------------------------------------------------------
	// Error handling and compare tasks
	// ----------------------------------------------------------------------
	task automatic stop_run(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (act !== exp)
			stop_run($sformatf("FAIL %s: expected %08h, actual %08h", name, exp, act));
	endtask

	task automatic check_ctrl(input string name, input board_pkg::ctrl_regs_t exp,
			input board_pkg::ctrl_regs_t act);
		if (act !== exp)
			stop_run($sformatf("FAIL %s: expected %07h, actual %07h", name, exp, act));
	endtask

	task automatic check_pulse(input string name, input logic [3:0] exp,
			input logic [3:0] act);
		if (act !== exp)
			stop_run($sformatf("FAIL %s: expected %04b, actual %04b", name, exp, act));
	endtask

	// ----------------------------------------------------------------------
	// Bus tasks
	// ----------------------------------------------------------------------

	// Returns just after the edge that samples the strobe
	task automatic bus_write(input logic [23:0] a, input logic [31:0] d);
		@(posedge clk);
		addr           <= a;
		data_out       <= d;
		control_rd     <= 1'b0;
		control_strobe <= 1'b1;
		@(posedge clk);
		control_strobe <= 1'b0;
	endtask

	// Fixed latency, result stable by the falling edge after stage two
	task automatic bus_read(input logic [23:0] a, output logic [31:0] d);
		@(posedge clk);
		addr           <= a;
		control_rd     <= 1'b1;
		control_strobe <= 1'b1;
		@(posedge clk);
		control_strobe <= 1'b0;
		control_rd     <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		d = data_in;
	endtask

	task automatic read_check(input string name, input logic [23:0] a,
			input logic [31:0] exp);
		logic [31:0] d;
		bus_read(a, d);
		check_word(name, exp, d);
	endtask

	// One read per cycle, each result checked two edges after its drive
	task automatic read_mirror_burst();
		for (int i = 0; i < 34; i++) begin
			@(posedge clk);
			if (i < 32) begin
				addr           <= 24'h050000 + 24'(i);
				control_rd     <= 1'b1;
				control_strobe <= 1'b1;
			end else begin
				control_strobe <= 1'b0;
				control_rd     <= 1'b0;
			end
			@(negedge clk);
			if (i >= 2)
				check_word("mirror burst", mirror_exp[i-2], data_in);
		end
	endtask

	// Control state as seen on the pins and in bank offsets 6 and 7
	task automatic compare_ctrl_observed(input string name);
		logic [31:0]           w6;
		logic [31:0]           w7;
		board_pkg::ctrl_regs_t act;
		bus_read(24'h000006, w6);
		bus_read(24'h000007, w7);
		act.led_user    = led_user_mode;
		act.misc_config = {ext_config, cfg_enables};
		act.led1_duty   = w7[7:0];
		act.led2_duty   = w7[15:8];
		check_ctrl(name, ctrl_exp, act);
		check_word(name, {24'h0, ctrl_exp.misc_config}, w6);
		check_word(name, {16'h0, ctrl_exp.led2_duty, ctrl_exp.led1_duty}, w7);
	endtask

	task automatic wait_led1_rise();
		logic prev;
		logic seen;
		prev = 1'b1;
		seen = 1'b0;
		for (int n = 0; n < wait_limit && !seen; n++) begin
			@(negedge clk);
			seen = led1 && !prev;
			prev = led1;
		end
		if (!seen)
			stop_run("timeout: led1 never went high after the duty write");
	endtask

	// ----------------------------------------------------------------------
	// Tests
	// ----------------------------------------------------------------------
	task automatic test_reset_id();
		check_word("reset_id config", 32'(misc_config_default), {24'h0, ext_config, cfg_enables});
		read_check("reset_id word 0", 24'h000000, lb_bus_pkg::id_word_0);
		read_check("reset_id word 1", 24'h000001, lb_bus_pkg::id_word_1);
		read_check("reset_id word 2", 24'h000002, lb_bus_pkg::id_word_2);
		read_check("reset_id word 3", 24'h000003, lb_bus_pkg::id_word_3);
		read_check("reset_id offset 8", 24'h000008, {23'h0, pin_status});
		read_check("reset_id offset 9", 24'h000009, "zzzz");
		read_check("reset_id unmapped", 24'h030000, 32'hdeadbeef);
	endtask

	task automatic test_ctrl_regs();
		logic [31:0] r;
		ctrl_exp = '{led_user: 1'b0, led1_duty: 8'h00, led2_duty: 8'h00,
			misc_config: misc_config_default};
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			bus_write(24'h050001, r);
			ctrl_exp.led_user = r[0];
			r = $random(seed);
			bus_write(24'h050002, r);
			ctrl_exp.led1_duty = r[7:0];
			r = $random(seed);
			bus_write(24'h050003, r);
			ctrl_exp.led2_duty = r[7:0];
			r = $random(seed);
			bus_write(24'h050008, r);
			ctrl_exp.misc_config = r[7:0];
			compare_ctrl_observed("ctrl_regs write");
		end
		// Offset 5 only lands in the mirror
		r = $random(seed);
		bus_write(24'h050005, r);
		compare_ctrl_observed("ctrl_regs offset 5");
	endtask

	task automatic test_mirror();
		for (int i = 0; i < 32; i++) begin
			mirror_exp[i] = $random(seed);
			bus_write(24'h050000 + 24'(i), mirror_exp[i]);
		end
		read_mirror_burst();
	endtask

	task automatic test_triggers();
		for (int i = 0; i < 4; i++) begin
			bus_write(24'h050009 + 24'(i), $random(seed));
			@(negedge clk);
			check_pulse("trigger pulse", 4'(1 << i), trig);
			@(negedge clk);
			check_pulse("trigger clear", 4'b0000, trig);
		end
	endtask

	task automatic test_pwm_counters();
		int          high_cnt;
		int          high2_cnt;
		int          k;
		logic [31:0] up0;
		logic [31:0] up1;
		bus_write(24'h050003, 32'd32);
		bus_write(24'h050002, 32'd64);
		wait_led1_rise();
		high_cnt  = 0;
		high2_cnt = 0;
		for (int n = 0; n < pwm_period; n++) begin
			if (led1)
				high_cnt++;
			if (led2)
				high2_cnt++;
			@(negedge clk);
		end
		check_word("pwm led1 high cycles", 32'd256, high_cnt);
		check_word("pwm led2 high cycles", 32'd128, high2_cnt);

		k = ($random(seed) & 32'h1f) + 1;
		for (int n = 0; n < k; n++) begin
			@(posedge clk);
			xdomain_fault <= 1'b1;
		end
		@(posedge clk);
		xdomain_fault <= 1'b0;
		read_check("fault count", 24'h000004, k);

		// Sample edges of the two reads sit exactly one period apart
		bus_read(24'h000005, up0);
		repeat (pwm_period - 3) @(posedge clk);
		bus_read(24'h000005, up1);
		check_word("uptime step", up0 + 1, up1);
	endtask

	initial begin
		clk            = 1'b0;
		rst            = 1'b1;
		addr           = '0;
		control_strobe = 1'b0;
		control_rd     = 1'b0;
		data_out       = '0;
		xdomain_fault  = 1'b0;
		pin_status     = 9'h1a5;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		test_reset_id();
		test_ctrl_regs();
		test_mirror();
		test_triggers();
		test_pwm_counters();
		$display("sim passed");
		$finish;
	end

endmodule

//--- lb_slave.f
lb_bus_pkg.sv
board_pkg.sv
lb_decode.sv
lb_ctrl_regs.sv
lb_mirror.sv
led_pwm_status.sv
lb_read_mux.sv
lb_slave_top.sv
lb_slave_tb.sv
